// File: filelist.f
hdl/wide_mod_pkg.sv
hdl/stream_ifs.sv
hdl/wb_operand_regs.sv
hdl/mod_reduce_ctrl.sv
hdl/digit_residue_unit.sv
hdl/residue_accumulator.sv
hdl/wide_mod_top.sv
tests/tb_wide_mod.sv

// File: Bender.yml
package:
  name: wide_mod

dependencies: {}

sources:
  # design sources in compile order
  - files:
      - hdl/wide_mod_pkg.sv
      - hdl/stream_ifs.sv
      - hdl/wb_operand_regs.sv
      - hdl/mod_reduce_ctrl.sv
      - hdl/digit_residue_unit.sv
      - hdl/residue_accumulator.sv
      - hdl/wide_mod_top.sv

  # testbench, top module tb_wide_mod
  - target: test
    files:
      - tests/tb_wide_mod.sv

// File: tests/tb_wide_mod.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wide_mod
  import wide_mod_pkg::*;
();

  localparam int OPERAND_BITS   = DEFAULT_OPERAND_BITS;
  localparam int MODULUS        = DEFAULT_MODULUS;
  localparam int NUM_DIGITS     = (OPERAND_BITS + DIGIT_BITS - 1) / DIGIT_BITS;
  localparam int WIDE_BITS      = OPERAND_WORDS * WB_DATA_BITS;
  localparam int TEST_COUNT     = 5;
  localparam int TIMEOUT_CYCLES = TEST_COUNT * 40 * 70 + 2000;

  logic        clk;
  logic        rst_n;
  logic        cyc;
  logic        stb;
  logic        we;
  wb_addr_t    adr;
  wb_data_t    dat_w;
  wb_data_t    dat_r;
  logic        ack;
  logic        irq;
  int unsigned cycle_count = 0;
  int unsigned last_ack_cycle;  // cycle in which the last bus ack was seen

  wide_mod_top #(
    .OPERAND_BITS(OPERAND_BITS),
    .MODULUS     (MODULUS)
  ) DUT (
    .clk  (clk),
    .rst_n(rst_n),
    .cyc  (cyc),
    .stb  (stb),
    .we   (we),
    .adr  (adr),
    .dat_w(dat_w),
    .dat_r(dat_r),
    .ack  (ack),
    .irq  (irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial
  begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout after %0d cycles, the tests did not finish", cycle_count);
    abort_run();
  end

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_residue(input string name, input residue_t got, input residue_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // one classic cycle; ack is sampled on the falling edge where it is stable
  task automatic wb_access(input logic write, input wb_addr_t a, input wb_data_t d,
                           output wb_data_t rd);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= a;
    dat_w <= d;
    do
    begin
      @(negedge clk);
    end
    while (!ack);
    last_ack_cycle = cycle_count;
    rd = dat_r;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    @(negedge clk);
    check_bit("ack after one cycle", ack, 1'b0);  // ack lasts exactly one clock
  endtask

  task automatic wb_write(input wb_addr_t a, input wb_data_t d);
    wb_data_t unused;
    wb_access(1'b1, a, d, unused);
  endtask

  task automatic wb_read(input wb_addr_t a, output wb_data_t d);
    wb_access(1'b0, a, '0, d);
  endtask

  task automatic load_operand(input logic [WIDE_BITS-1:0] op);
    for (int i = 0; i < OPERAND_WORDS; i++)
    begin
      wb_write(wb_addr_t'(ADDR_OPERAND_BASE + i), op[i*WB_DATA_BITS +: WB_DATA_BITS]);
    end
  endtask

  // horner's rule over 6-bit digits, most significant digit first
  task automatic model_residue(input logic [WIDE_BITS-1:0] op, output residue_t r);
    int acc;
    int dig;
    op  = op & ({WIDE_BITS{1'b1}} >> (WIDE_BITS - OPERAND_BITS));
    acc = 0;
    for (int k = NUM_DIGITS - 1; k >= 0; k--)
    begin
      dig = int'(op[k*DIGIT_BITS +: DIGIT_BITS]);
      acc = (acc * (1 << DIGIT_BITS) + dig) % MODULUS;
    end
    r = residue_t'(acc);
  endtask

  function automatic wb_data_t word_keep_mask(input int idx);
    int kept;
    kept = OPERAND_BITS - idx * WB_DATA_BITS;
    if (kept >= WB_DATA_BITS)
      return '1;
    if (kept <= 0)
      return '0;
    return wb_data_t'((64'd1 << kept) - 1);
  endfunction

  task automatic wait_irq();
    do
    begin
      @(negedge clk);
    end
    while (!irq);
  endtask

  task automatic finish_reduction(input residue_t exp);
    wb_data_t st;
    wb_data_t rd;
    do
    begin
      wb_read(ADDR_STATUS, st);
    end
    while (!st[1]);
    check_word("status", st, 32'h2);  // done set and busy clear
    @(negedge clk);
    check_bit("irq", irq, 1'b1);
    wb_read(ADDR_RESULT, rd);
    check_residue("result", residue_t'(rd), exp);
    check_word("result upper bits", rd >> RESIDUE_BITS, '0);
  endtask

  task automatic run_reduction(input logic [WIDE_BITS-1:0] op, input residue_t exp);
    load_operand(op);
    wb_write(ADDR_CTRL, 32'h1);
    finish_reduction(exp);
  endtask

  task automatic reset_readout();
    wb_data_t rd;
    wb_read(ADDR_STATUS, rd);
    check_word("status after reset", rd, '0);
    wb_read(ADDR_RESULT, rd);
    check_word("result after reset", rd, '0);
    @(negedge clk);
    check_bit("irq after reset", irq, 1'b0);
  endtask

  task automatic operand_readback();
    logic [WIDE_BITS-1:0] op;
    wb_data_t             rd;
    for (int i = 0; i < OPERAND_WORDS; i++)
      op[i*WB_DATA_BITS +: WB_DATA_BITS] = $urandom();
    op[(OPERAND_WORDS-1)*WB_DATA_BITS +: WB_DATA_BITS] = '1; // top word fully set
    load_operand(op);
    for (int i = 0; i < OPERAND_WORDS; i++)
    begin
      wb_read(wb_addr_t'(ADDR_OPERAND_BASE + i), rd);
      check_word($sformatf("operand word %0d", i), rd,
                 op[i*WB_DATA_BITS +: WB_DATA_BITS] & word_keep_mask(i));
    end
  endtask

  task automatic fixed_operand_runs();
    logic [WIDE_BITS-1:0] op;
    residue_t             exp;
    run_reduction('0, residue_t'(0));
    run_reduction(WIDE_BITS'(1234), residue_t'(1234 % MODULUS));
    op = '1;
    model_residue(op, exp);
    run_reduction(op, exp);
  endtask

  task automatic random_operand_runs();
    logic [WIDE_BITS-1:0] op;
    residue_t             exp;
    for (int n = 0; n < 20; n++)
    begin
      for (int i = 0; i < OPERAND_WORDS; i++)
        op[i*WB_DATA_BITS +: WB_DATA_BITS] = $urandom();
      model_residue(op, exp);
      run_reduction(op, exp);
    end
  endtask

  task automatic busy_handling();
    logic [WIDE_BITS-1:0] op_a;
    logic [WIDE_BITS-1:0] op_b;
    residue_t             exp_a;
    residue_t             exp_b;
    wb_data_t             rd;
    int unsigned          start_cycle;
    for (int i = 0; i < OPERAND_WORDS; i++)
      op_a[i*WB_DATA_BITS +: WB_DATA_BITS] = $urandom();
    op_b        = op_a;
    op_b[31:0]  = ~op_a[31:0];
    model_residue(op_a, exp_a);
    model_residue(op_b, exp_b);
    load_operand(op_a);

    wb_write(ADDR_CTRL, 32'h1);
    start_cycle = last_ack_cycle;
    wb_write(ADDR_CTRL, 32'h1);  // lands while busy and must not restart the run
    wait_irq();
    check_word("start to irq cycles", wb_data_t'(cycle_count - start_cycle),
               wb_data_t'(NUM_DIGITS + 3));
    finish_reduction(exp_a);

    wb_write(ADDR_CTRL, 32'h1);
    start_cycle = last_ack_cycle;
    wb_write(ADDR_OPERAND_BASE, op_b[31:0]);  // held off until busy falls
    check_word("stalled write ack cycles", wb_data_t'(last_ack_cycle - start_cycle),
               wb_data_t'(NUM_DIGITS + 4));
    finish_reduction(exp_a);
    wb_read(ADDR_OPERAND_BASE, rd);
    check_word("operand word 0 after stall", rd, op_b[31:0]);

    wb_write(ADDR_CTRL, 32'h1);
    finish_reduction(exp_b);
  endtask

  initial
  begin
    void'($urandom(32'hd4d45087));
    rst_n = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    reset_readout();
    operand_readback();
    fixed_operand_runs();
    random_operand_runs();
    busy_handling();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/wide_mod_top.sv
`timescale 1ns/1ps
`default_nettype none

module wide_mod_top
  import wide_mod_pkg::*;
#(
  parameter int OPERAND_BITS = DEFAULT_OPERAND_BITS,
  parameter int MODULUS      = DEFAULT_MODULUS
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cyc,
  input  logic     stb,
  input  logic     we,
  input  wb_addr_t adr,
  input  wb_data_t dat_w,
  output wb_data_t dat_r,
  output logic     ack,
  output logic     irq
);

  logic [OPERAND_BITS-1:0] operand;
  logic                    start;
  logic                    busy;
  logic                    done;
  logic                    result_valid;
  residue_t                result;

  digit_if   digits ();
  residue_if residues ();

  assign irq = done;

  wb_operand_regs #(
    .OPERAND_BITS(OPERAND_BITS)
  ) u_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .dat_w  (dat_w),
    .dat_r  (dat_r),
    .ack    (ack),
    .operand(operand),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  mod_reduce_ctrl #(
    .OPERAND_BITS(OPERAND_BITS)
  ) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .operand     (operand),
    .start       (start),
    .digits      (digits.source),
    .result_valid(result_valid),
    .busy        (busy),
    .done        (done)
  );

  digit_residue_unit #(
    .MODULUS(MODULUS)
  ) u_digit (
    .clk     (clk),
    .rst_n   (rst_n),
    .digits  (digits.sink),
    .residues(residues.source)
  );

  residue_accumulator #(
    .MODULUS(MODULUS)
  ) u_acc (
    .clk         (clk),
    .rst_n       (rst_n),
    .residues    (residues.sink),
    .result      (result),
    .result_valid(result_valid)
  );

endmodule

`default_nettype wire

// File: hdl/residue_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module residue_accumulator
  import wide_mod_pkg::*;
#(
  parameter int MODULUS = DEFAULT_MODULUS
) (
  input  logic    clk,
  input  logic    rst_n,
  residue_if.sink residues,
  output residue_t result,
  output logic     result_valid
);

  residue_t              acc_q;
  residue_t              base;
  residue_t              folded;
  logic [RESIDUE_BITS:0] sum_next;  // both terms are below the modulus

  assign base     = residues.first ? '0 : acc_q;
  assign sum_next = base + residues.residue;
  assign folded   = (sum_next >= MODULUS) ? residue_t'(sum_next - MODULUS)
                                          : residue_t'(sum_next);

  // marks the cycle in which the final sum is captured into result
  assign result_valid = residues.valid & residues.last;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_q  <= '0;
      result <= '0;
    end
    else if (residues.valid)
    begin
      acc_q <= folded;
      if (residues.last)
      begin
        result <= folded;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/digit_residue_unit.sv
`timescale 1ns/1ps
`default_nettype none

module digit_residue_unit
  import wide_mod_pkg::*;
#(
  parameter int MODULUS = DEFAULT_MODULUS
) (
  input  logic      clk,
  input  logic      rst_n,
  digit_if.sink     digits,
  residue_if.source residues
);

  localparam residue_t WEIGHT_INIT = residue_t'(pow2_mod(0, MODULUS));
  localparam residue_t WEIGHT_STEP = residue_t'(pow2_mod(DIGIT_BITS, MODULUS)); // 64 mod M

  residue_t                  weight_q;  // weight of the next digit in the run
  residue_t                  cur_weight;
  logic [2*RESIDUE_BITS-1:0] weight_prod;
  logic [2*RESIDUE_BITS-1:0] s1_prod;
  logic                      s1_valid;
  logic                      s1_first;
  logic                      s1_last;

  assign cur_weight  = digits.first ? WEIGHT_INIT : weight_q;
  assign weight_prod = cur_weight * WEIGHT_STEP;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      weight_q       <= WEIGHT_INIT;
      s1_valid       <= 1'b0;
      residues.valid <= 1'b0;
    end
    else
    begin
      if (digits.valid)
      begin
        weight_q <= residue_t'(weight_prod % MODULUS);
      end
      s1_valid       <= digits.valid;
      residues.valid <= s1_valid;
    end
  end

  // stage 1 weights the digit, stage 2 folds the 12-bit product
  always_ff @(posedge clk)
  begin
    s1_prod           <= digits.digit * cur_weight;
    s1_first          <= digits.first;
    s1_last           <= digits.last;
    residues.residue  <= residue_t'(s1_prod % MODULUS);
    residues.first    <= s1_first;
    residues.last     <= s1_last;
  end

endmodule

`default_nettype wire

// File: hdl/mod_reduce_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mod_reduce_ctrl
  import wide_mod_pkg::*;
#(
  parameter int OPERAND_BITS = DEFAULT_OPERAND_BITS
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [OPERAND_BITS-1:0] operand,
  input  logic                    start,
  digit_if.source                 digits,
  input  logic                    result_valid,
  output logic                    busy,
  output logic                    done
);

  localparam int NUM_DIGITS  = (OPERAND_BITS + DIGIT_BITS - 1) / DIGIT_BITS;
  localparam int PADDED_BITS = NUM_DIGITS * DIGIT_BITS;
  localparam int IDX_BITS    = $clog2(NUM_DIGITS + 1);

  logic [PADDED_BITS-1:0] padded;
  logic [IDX_BITS-1:0]    idx;

  assign padded = PADDED_BITS'(operand); // top digit is zero filled

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      digits.valid <= 1'b0;
      idx          <= '0;
      busy         <= 1'b0;
      done         <= 1'b0;
    end
    else
    begin
      if (start)
      begin
        digits.valid <= 1'b1;
        idx          <= IDX_BITS'(1); // digit 0 goes out with the start
      end
      else if (digits.valid && digits.last)
      begin
        digits.valid <= 1'b0;
      end
      else if (digits.valid)
      begin
        idx <= idx + 1'b1;
      end

      if (start)
      begin
        busy <= 1'b1;
        done <= 1'b0;
      end
      else if (result_valid)
      begin
        busy <= 1'b0;
        done <= 1'b1;  // held until the next start
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      digits.digit <= padded[DIGIT_BITS-1:0];
      digits.first <= 1'b1;
      digits.last  <= (NUM_DIGITS == 1);
    end
    else if (digits.valid && !digits.last)
    begin
      digits.digit <= padded[idx*DIGIT_BITS +: DIGIT_BITS];
      digits.first <= 1'b0;
      digits.last  <= (idx == IDX_BITS'(NUM_DIGITS - 1));
    end
  end

endmodule

`default_nettype wire

// File: hdl/wb_operand_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_operand_regs
  import wide_mod_pkg::*;
#(
  parameter int OPERAND_BITS = DEFAULT_OPERAND_BITS
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  wb_addr_t                adr,
  input  wb_data_t                dat_w,
  output wb_data_t                dat_r,
  output logic                    ack,
  output logic [OPERAND_BITS-1:0] operand,
  output logic                    start,
  input  logic                    busy,
  input  logic                    done,
  input  residue_t                result
);

  localparam int TOTAL_BITS = OPERAND_WORDS * WB_DATA_BITS;
  localparam logic [TOTAL_BITS-1:0] KEEP_MASK =
    {TOTAL_BITS{1'b1}} >> (TOTAL_BITS - OPERAND_BITS);

  logic [TOTAL_BITS-1:0] words;
  wb_addr_t              word_idx;
  wb_data_t              rd_data;
  logic                  req;
  logic                  op_sel;
  logic                  engaged;
  logic                  stall;

  assign req      = cyc & stb & ~ack;   // a new request, not the one being acked
  assign word_idx = adr - ADDR_OPERAND_BASE;
  assign op_sel   = word_idx < OPERAND_WORDS;
  assign engaged  = busy | start;       // busy only rises the cycle after start
  assign stall    = we & op_sel & engaged;

  assign operand = words[OPERAND_BITS-1:0];

  always_comb
  begin
    rd_data = '0;
    if (op_sel)
    begin
      rd_data = words[word_idx*WB_DATA_BITS +: WB_DATA_BITS]
              & KEEP_MASK[word_idx*WB_DATA_BITS +: WB_DATA_BITS]; // bits past the operand read zero
    end
    else if (adr == ADDR_STATUS)
    begin
      rd_data = {{(WB_DATA_BITS - 2){1'b0}}, done, busy};
    end
    else if (adr == ADDR_RESULT)
    begin
      rd_data = {{(WB_DATA_BITS - RESIDUE_BITS){1'b0}}, result};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack   <= 1'b0;
      start <= 1'b0;
    end
    else
    begin
      ack   <= req & ~stall;  // operand writes wait here until the engine is idle
      start <= req & we & (adr == ADDR_CTRL) & dat_w[0] & ~engaged;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req && !stall)
    begin
      if (!we)
      begin
        dat_r <= rd_data;
      end
      else if (op_sel)
      begin
        words[word_idx*WB_DATA_BITS +: WB_DATA_BITS] <= dat_w;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/stream_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// operand digits, least significant first, one per clock
interface digit_if
  import wide_mod_pkg::*;
();

  logic   valid;
  logic   first;
  logic   last;
  digit_t digit;

  modport source (output valid, output first, output last, output digit);
  modport sink   (input valid, input first, input last, input digit);

endinterface

// weighted digit residues in the same order as the digits
interface residue_if
  import wide_mod_pkg::*;
();

  logic     valid;
  logic     first;
  logic     last;
  residue_t residue;

  modport source (output valid, output first, output last, output residue);
  modport sink   (input valid, input first, input last, input residue);

endinterface

`default_nettype wire

// File: hdl/wide_mod_pkg.sv
`default_nettype none

package wide_mod_pkg;

  localparam int DIGIT_BITS    = 6;
  localparam int RESIDUE_BITS  = 6;  // enough for any modulus up to 63
  localparam int OPERAND_WORDS = 10;
  localparam int WB_DATA_BITS  = 32;

  localparam int DEFAULT_OPERAND_BITS = 300;
  localparam int DEFAULT_MODULUS      = 53;

  typedef logic [RESIDUE_BITS-1:0] residue_t;
  typedef logic [DIGIT_BITS-1:0]   digit_t;
  typedef logic [WB_DATA_BITS-1:0] wb_data_t;
  typedef logic [3:0]              wb_addr_t;

  localparam wb_addr_t ADDR_OPERAND_BASE = 4'd0;  // words 0..9, least significant first
  localparam wb_addr_t ADDR_CTRL         = 4'd10; // bit 0 starts a reduction
  localparam wb_addr_t ADDR_STATUS       = 4'd11; // bit 0 busy, bit 1 done
  localparam wb_addr_t ADDR_RESULT       = 4'd12; // residue in the low bits

  // two to the given power, reduced modulo the given modulus
  function automatic int pow2_mod(input int exponent, input int modulus);
    int acc;
    acc = 1 % modulus;
    for (int i = 0; i < exponent; i++)
    begin
      acc = (acc * 2) % modulus;
    end
    return acc;
  endfunction

endpackage

`default_nettype wire
